// ==== sim/wbuf_vectors.txt ====
# fields in hex: W chan addr data | F chan page | B chan page len adv poke
# E chan page count word... | P chan_pages packed {ch3, ch2, ch1, ch0}
P 00
# even address low half, odd address high half
W 0 000 11110000
W 0 001 22220001
W 0 002 33330002
W 0 003 44440003
E 0 0 2 2222000111110000 4444000333330002
# same local address on three channels
W 1 000 aaaa0001
W 1 001 bbbb0001
W 2 000 aaaa0002
W 2 001 bbbb0002
E 1 0 1 bbbb0001aaaa0001
E 2 0 1 bbbb0002aaaa0002
E 0 0 1 2222000111110000
# page advance on channel 3
W 3 100 c0de0000
W 3 101 c0de0001
W 3 102 c0de0002
W 3 103 c0de0003
W 3 200 d00d0000
W 3 201 d00d0001
B 3 1 2 1 0
P 80
E 3 2 1 d00d0001d00d0000
P 80
# stray burst_start while busy
B 3 1 2 1 1
P 80
# random fills, every page of every channel
F 0 0
F 0 1
F 0 2
F 0 3
F 1 0
F 1 1
F 1 2
F 1 3
F 2 0
F 2 1
F 2 2
F 2 3
F 3 0
F 3 1
F 3 2
F 3 3
# full page bursts, page wrap 3 to 0 on channel 0
B 0 0 80 0 0
B 0 1 80 0 0
B 0 2 80 0 0
B 0 3 80 1 0
P 80
B 1 0 80 0 0
B 1 1 80 0 0
B 1 2 05 0 0
B 1 3 80 0 0
B 2 0 80 0 0
B 2 1 01 0 0
B 2 3 80 0 0
B 2 2 80 1 0
B 3 0 80 0 0
B 3 1 80 0 0
B 3 2 7f 0 0
B 3 3 80 1 0
P 3c

// ==== wbuf_top.f ====
+incdir+source
source/wbuf_pkg.sv
source/wbuf_ram.sv
source/channel_wbuf.sv
source/host_wr_decode.sv
source/burst_sequencer.sv
source/wbuf_top.sv
sim/wbuf_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the wbuf testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

TOP=wbuf_tb
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" -f wbuf_top.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== sim/wbuf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "wbuf_macros.svh"

// vector driven testbench for wbuf_top, shadow model of all host writes
module wbuf_tb
    import wbuf_pkg::*;
();

    localparam int PW    = $bits(page_t);
    localparam int LOCAL = 1 << $bits(host_addr_t);  // host words per channel

    logic                                        rclk = 1'b0;
    logic                                        reset;
    logic                                        host_we;
    logic [$bits(chan_t)+$bits(host_addr_t)-1:0] host_addr;     // {chan, local}
    host_data_t                                  host_data;
    logic                                        burst_start;
    chan_t                                       burst_chan;
    page_t                                       burst_page;
    burst_len_t                                  burst_len;
    logic                                        burst_adv;
    logic                                        mem_valid;
    mem_data_t                                   mem_data;
    logic                                        burst_busy;
    logic                                        burst_done;
    logic [`WBUF_CHANNELS*PW-1:0]                chan_pages;    // channel 0 lowest

    host_data_t  shadow [`WBUF_CHANNELS][LOCAL];  // mirror of host writes
    mem_data_t   exp_q [$];                       // words still due this burst
    mem_data_t   ev_q [$];                        // E vector words, file order
    logic [7:0]  cmd_q [$];                       // command letters
    logic [31:0] arg_q [$];                       // hex fields, all commands
    logic [31:0] rng = 32'hf136_a444;             // xorshift state
    int          mismatches = 0;
    int          other_errs = 0;
    int          words = 0;                       // burst words compared
    int          cycles = 0;
    int          cycle_limit = 0;                 // 0 until vectors loaded

    wbuf_top dut_i (
        .rclk        (rclk),
        .reset       (reset),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .burst_start (burst_start),
        .burst_chan  (burst_chan),
        .burst_page  (burst_page),
        .burst_len   (burst_len),
        .burst_adv   (burst_adv),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .burst_busy  (burst_busy),
        .burst_done  (burst_done),
        .chan_pages  (chan_pages)
    );

    always #20 rclk = ~rclk;   // 40 ns period

    always @(posedge rclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("errors: %0d mismatches, %0d other, %0d words checked",
                     mismatches, other_errs + 1, words);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // hex fields that follow each command letter
    function automatic int field_count(input logic [7:0] cmd);
        case (cmd)
            "W":     return 3;   // chan addr data
            "F":     return 2;   // chan page
            "B":     return 5;   // chan page len adv poke
            "E":     return 3;   // chan page count, then the words
            default: return 1;   // P, packed chan_pages
        endcase
    endfunction

    task automatic check_mem_data(input mem_data_t got, input mem_data_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_page(input page_t got, input page_t exp, input int c);
        if (got !== exp) begin
            $display("mismatch at %0t: channel %0d page got %0d expected %0d", $time, c, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic load_vectors();
        int                fd;
        int                r;
        logic [63:0]       tok;
        logic [8*160-1:0]  line;
        logic [31:0]       v;
        mem_data_t         w;
        fd = $fopen("sim/wbuf_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/wbuf_vectors.txt");
            other_errs++;
            return;
        end
        cycle_limit = 16 + 20;                         // reset plus slack
        while (!$feof(fd)) begin
            r = $fscanf(fd, " %s", tok);
            if (r != 1) break;
            if (tok[7:0] == "#") begin
                r = $fgets(line, fd);                  // rest of comment line
            end else begin
                cmd_q.push_back(tok[7:0]);
                for (int k = 0; k < field_count(tok[7:0]); k++) begin
                    r = $fscanf(fd, " %h", v);
                    arg_q.push_back(v);
                end
                case (tok[7:0])
                    "W": cycle_limit += 50;
                    "F": cycle_limit += 2 * (1 << `WBUF_DEPTH_LOG2) + 50;
                    "B": cycle_limit += int'(arg_q[arg_q.size()-3][7:0]) + 20;  // len field
                    "E": begin
                        cycle_limit += int'(v) + 20;
                        for (int k = 0; k < int'(v); k++) begin
                            r = $fscanf(fd, " %h", w);
                            ev_q.push_back(w);
                        end
                    end
                    "P": ;
                    default: begin
                        $display("unknown vector command %s", tok);
                        other_errs++;
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic host_write(input chan_t c, input logic [$bits(host_addr_t)-1:0] a,
                              input host_data_t d);
        @(negedge rclk);
        host_we     = 1'b1;
        host_addr   = {c, a};
        host_data   = d;
        shadow[c][a] = d;      // RAM takes it two edges on
    endtask

    task automatic host_idle();
        @(negedge rclk);
        host_we = 1'b0;
    endtask

    task automatic fill_page(input chan_t c, input page_t p);
        for (int w = 0; w < (1 << `WBUF_DEPTH_LOG2); w++) begin
            for (int h = 0; h < 2; h++) begin
                rng = xorshift32(rng);
                host_write(c, {p, mem_addr_t'(w), h[0]}, rng);
            end
        end
        host_idle();
    endtask

    // one burst, words compared in order as mem_valid shows them
    task automatic run_burst(input chan_t c, input page_t p, input burst_len_t len,
                             input logic adv, input logic poke, input logic from_file);
        int   wait_cyc;
        logic done;
        for (int i = 0; i < int'(len); i++) begin
            if (from_file) begin
                exp_q.push_back(ev_q.pop_front());
            end else begin
                exp_q.push_back({shadow[c][{p, mem_addr_t'(i), 1'b1}],
                                 shadow[c][{p, mem_addr_t'(i), 1'b0}]});  // odd addr high
            end
        end
        @(negedge rclk);
        while (burst_busy) @(negedge rclk);
        burst_start = 1'b1;
        burst_chan  = c;
        burst_page  = p;
        burst_len   = len;
        burst_adv   = adv;
        wait_cyc    = 0;
        done        = 1'b0;
        while (!done && wait_cyc < int'(len) + 20) begin
            @(negedge rclk);
            wait_cyc++;
            burst_start = poke && (wait_cyc == 1);        // stray start, sequencer busy
            burst_chan  = poke ? c + chan_t'(1) : c;
            check_flag(burst_busy, 1'b1, "burst_busy during burst");
            if (mem_valid) begin
                words++;
                if (exp_q.size() == 0) begin
                    $display("unexpected mem_valid word at %0t on channel %0d", $time, c);
                    other_errs++;
                end else begin
                    check_mem_data(mem_data, exp_q.pop_front(), "burst word");
                end
                done = burst_done;
                if (burst_done && exp_q.size() != 0) begin
                    $display("burst_done at %0t with %0d words still due", $time, exp_q.size());
                    other_errs++;
                end
            end else if (burst_done) begin
                $display("burst_done without mem_valid at %0t", $time);
                other_errs++;
            end
        end
        if (!done) begin
            $display("burst_done missing for channel %0d page %0d", c, p);
            other_errs++;
        end
        exp_q.delete();
        repeat (4) begin
            @(negedge rclk);
            check_flag(burst_busy, 1'b0, "burst_busy after burst");
            if (mem_valid) begin
                $display("extra mem_valid word after burst at %0t", $time);
                other_errs++;
            end
        end
    endtask

    initial begin
        logic [7:0]  cmd;
        logic [31:0] f [5];
        host_we     = 1'b0;
        host_addr   = '0;
        host_data   = '0;
        burst_start = 1'b0;
        burst_chan  = '0;
        burst_page  = '0;
        burst_len   = '0;
        burst_adv   = 1'b0;
        reset       = 1'b1;
        load_vectors();
        repeat (16) @(negedge rclk);
        reset = 1'b0;
        @(negedge rclk);
        check_flag(mem_valid, 1'b0, "mem_valid after reset");
        check_flag(burst_busy, 1'b0, "burst_busy after reset");
        while (cmd_q.size() > 0) begin
            cmd = cmd_q.pop_front();
            for (int k = 0; k < field_count(cmd); k++) begin
                f[k] = arg_q.pop_front();
            end
            case (cmd)
                "W": begin
                    host_write(chan_t'(f[0]), f[1][$bits(host_addr_t)-1:0], f[2]);
                    host_idle();
                end
                "F": fill_page(chan_t'(f[0]), page_t'(f[1]));
                "B": run_burst(chan_t'(f[0]), page_t'(f[1]), burst_len_t'(f[2]),
                               f[3][0], f[4][0], 1'b0);
                "E": run_burst(chan_t'(f[0]), page_t'(f[1]), burst_len_t'(f[2]),
                               1'b0, 1'b0, 1'b1);
                "P": begin
                    @(negedge rclk);
                    for (int i = 0; i < `WBUF_CHANNELS; i++) begin
                        check_page(chan_pages[i*PW +: PW], f[0][i*PW +: PW], i);
                    end
                end
                default: ;
            endcase
        end
        repeat (4) @(negedge rclk);
        $display("errors: %0d mismatches, %0d other, %0d words checked",
                 mismatches, other_errs, words);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/wbuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "wbuf_macros.svh"

// write staging buffer: host decoder, channel buffers, burst sequencer
module wbuf_top
    import wbuf_pkg::*;
(
    input  wire logic                                      rclk,
    input  wire logic                                      reset,
    input  wire logic                                      host_we,
    input  wire logic [$bits(chan_t)+$bits(host_addr_t)-1:0] host_addr, // {chan, local}
    input  wire host_data_t                                host_data,
    input  wire logic                                      burst_start,
    input  wire chan_t                                     burst_chan,
    input  wire page_t                                     burst_page,
    input  wire burst_len_t                                burst_len,
    input  wire logic                                      burst_adv,
    output wire logic                                      mem_valid,
    output wire mem_data_t                                 mem_data,
    output wire logic                                      burst_busy,
    output wire logic                                      burst_done,
    output wire logic [`WBUF_CHANNELS*$bits(page_t)-1:0]    chan_pages  // channel 0 lowest
);

    localparam int PW = $bits(page_t);     // page field width in chan_pages

    logic [`WBUF_CHANNELS-1:0] wr_sel;        // host write select
    logic [`WBUF_CHANNELS-1:0] page_set_sel;
    logic [`WBUF_CHANNELS-1:0] page_next_sel;
    logic [`WBUF_CHANNELS-1:0] rd_sel;
    host_addr_t               wr_addr;
    host_data_t               wr_data;
    page_t                    page_val;      // shared page load value
    mem_data_t                chan_data [`WBUF_CHANNELS];

    host_wr_decode host_wr_decode_i (
        .rclk      (rclk),
        .reset     (reset),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_data (host_data),
        .wr_sel    (wr_sel),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    for (genvar i = 0; i < `WBUF_CHANNELS; i++) begin : g_chan
        channel_wbuf channel_wbuf_i (
            .rclk      (rclk),
            .reset     (reset),
            .we        (wr_sel[i]),
            .waddr     (wr_addr),
            .data_in   (wr_data),
            .rpage_in  (page_val),
            .rpage_set (page_set_sel[i]),
            .page_next (page_next_sel[i]),
            .rd        (rd_sel[i]),
            .page      (chan_pages[i*PW +: PW]),
            .data_out  (chan_data[i])
        );
    end

    burst_sequencer burst_sequencer_i (
        .rclk          (rclk),
        .reset         (reset),
        .burst_start   (burst_start),
        .burst_chan    (burst_chan),
        .burst_page    (burst_page),
        .burst_len     (burst_len),
        .burst_adv     (burst_adv),
        .chan_data     (chan_data),
        .page_set_sel  (page_set_sel),
        .page_next_sel (page_next_sel),
        .rd_sel        (rd_sel),
        .page_val      (page_val),
        .mem_valid     (mem_valid),
        .mem_data      (mem_data),
        .burst_busy    (burst_busy),
        .burst_done    (burst_done)
    );

endmodule

`default_nettype wire

// ==== source/burst_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "wbuf_macros.svh"

// one burst at a time: set page, issue reads, track valid through RAM pipe
module burst_sequencer
    import wbuf_pkg::*;
(
    input  wire logic                 rclk,
    input  wire logic                 reset,
    input  wire logic                 burst_start,   // sampled in idle only
    input  wire chan_t                burst_chan,
    input  wire page_t                burst_page,
    input  wire burst_len_t           burst_len,     // 1..128
    input  wire logic                 burst_adv,     // step page after burst
    input  wire mem_data_t            chan_data [`WBUF_CHANNELS],
    output logic [`WBUF_CHANNELS-1:0]  page_set_sel,
    output logic [`WBUF_CHANNELS-1:0]  page_next_sel,
    output logic [`WBUF_CHANNELS-1:0]  rd_sel,
    output page_t                     page_val,      // page for page_set
    output logic                      mem_valid,
    output mem_data_t                 mem_data,
    output logic                      burst_busy,
    output logic                      burst_done     // with last mem_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SET,     // page load pulse
        S_READ,    // rd pulses
        S_DRAIN    // wait for pipe to empty
    } state_t;

    state_t     state;
    chan_t      chan_r;    // latched burst channel
    page_t      page_r;    // latched burst page
    logic       adv_r;     // latched advance flag
    burst_len_t rd_cnt;    // reads left, incl. current
    logic       rd_last;   // final read this cycle
    logic       v_reg;     // word in latch, regen stage
    logic       v_out;     // word on data_out
    logic       l_reg;     // last tag, regen stage
    logic       l_out;     // last tag, output stage

    assign rd_last = (state == S_READ) && (rd_cnt == burst_len_t'(1));

    always_ff @(posedge rclk) begin
        if (reset) begin
            state  <= S_IDLE;
            rd_cnt <= '0;
            v_reg  <= 1'b0;
            v_out  <= 1'b0;
            l_reg  <= 1'b0;
            l_out  <= 1'b0;
        end else begin
            v_reg <= (state == S_READ);     // mirrors channel regen
            v_out <= v_reg;
            l_reg <= rd_last;
            l_out <= l_reg;
            case (state)
                S_IDLE: begin
                    if (burst_start) begin
                        state  <= S_SET;
                        rd_cnt <= burst_len;
                    end
                end
                S_SET: begin
                    state <= S_READ;
                end
                S_READ: begin
                    rd_cnt <= rd_cnt - burst_len_t'(1);
                    if (rd_last) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (l_out) begin
                        state <= S_IDLE;        // done with last word
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // burst parameters, held until next start
    always_ff @(posedge rclk) begin
        if (state == S_IDLE && burst_start) begin
            chan_r <= burst_chan;
            page_r <= burst_page;
            adv_r  <= burst_adv;
        end
    end

    assign page_set_sel  = (state == S_SET)  ? chan_onehot(chan_r) : '0;
    assign rd_sel        = (state == S_READ) ? chan_onehot(chan_r) : '0;
    assign page_next_sel = (l_reg && adv_r)  ? chan_onehot(chan_r) : '0; // after last regen
    assign page_val      = page_r;
    assign mem_valid     = v_out;
    assign mem_data      = chan_data[chan_r];   // active channel only
    assign burst_busy    = (state != S_IDLE);
    assign burst_done    = l_out;

    a_no_start_busy: assert property (@(posedge rclk) disable iff (reset)
        burst_busy |-> !burst_start)
        else $warning("burst_sequencer: burst_start ignored while busy");

    a_len_nonzero: assert property (@(posedge rclk) disable iff (reset)
        (burst_start && !burst_busy) |-> (burst_len != '0))
        else $error("burst_sequencer: zero burst_len accepted");

endmodule

`default_nettype wire

// ==== source/host_wr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "wbuf_macros.svh"

// host write register, channel field to one-hot select
module host_wr_decode
    import wbuf_pkg::*;
(
    input  wire logic                                      rclk,
    input  wire logic                                      reset,
    input  wire logic                                      host_we,
    input  wire logic [$bits(chan_t)+$bits(host_addr_t)-1:0] host_addr, // {chan, local}
    input  wire host_data_t                                host_data,
    output logic [`WBUF_CHANNELS-1:0]                       wr_sel,    // one-hot, 1 cycle late
    output host_addr_t                                     wr_addr,   // shared by channels
    output host_data_t                                     wr_data    // shared by channels
);

    chan_t      host_chan;   // channel field
    host_addr_t host_local;  // page, word, half

    assign host_chan  = host_addr[$bits(host_addr)-1 -: $bits(chan_t)];
    assign host_local = host_addr[$bits(host_addr_t)-1:0];

    // select strobe, cleared on reset
    always_ff @(posedge rclk) begin
        if (reset) begin
            wr_sel <= '0;
        end else if (host_we) begin
            wr_sel <= chan_onehot(host_chan);
        end else begin
            wr_sel <= '0;
        end
    end

    // address and data ride alongside wr_sel
    always_ff @(posedge rclk) begin
        if (host_we) begin
            wr_addr <= host_local;
            wr_data <= host_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/channel_wbuf.sv ====
`timescale 1ns/1ps
`default_nettype none

// one channel: paged buffer with auto-incrementing read address
module channel_wbuf
    import wbuf_pkg::*;
(
    input  wire logic       rclk,
    input  wire logic       reset,
    input  wire logic       we,         // host write, this channel
    input  wire host_addr_t waddr,      // local host address
    input  wire host_data_t data_in,    // host word
    input  wire page_t      rpage_in,   // page to load
    input  wire logic       rpage_set,  // load page from rpage_in
    input  wire logic       page_next,  // step to next page
    input  wire logic       rd,         // read one word, bump address
    output page_t           page,       // current read page
    output mem_data_t       data_out    // 2 cycles after rd
);

    mem_addr_t raddr;   // word within current page
    logic      regen;   // rd one cycle late

    always_ff @(posedge rclk) begin
        if (reset) begin
            page  <= '0;
            raddr <= '0;
            regen <= 1'b0;
        end else begin
            regen <= rd;                            // output reg follows latch
            if (rpage_set) begin
                page <= rpage_in;
            end else if (page_next) begin
                page <= page + page_t'(1);          // wraps mod 4
            end
            if (rpage_set || page_next) begin
                raddr <= '0;                        // restart at word 0
            end else if (rd) begin
                raddr <= raddr + mem_addr_t'(1);
            end
        end
    end

    wbuf_ram wbuf_ram_i (
        .rclk     (rclk),
        .we       (we),
        .waddr    (waddr),          // {page, word, half}
        .data_in  (data_in),
        .ren      (rd),
        .raddr    ({page, raddr}),  // current page
        .regen    (regen),
        .data_out (data_out)
    );

    // page load and page step come from one FSM state each
    a_page_ctl_excl: assert property (@(posedge rclk) disable iff (reset)
        !(rpage_set && page_next))
        else $error("channel_wbuf: rpage_set and page_next together");

endmodule

`default_nettype wire

// ==== source/wbuf_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "wbuf_macros.svh"

// 512 x 64 buffer, written 32 bits at a time, read 64 bits through two stages
module wbuf_ram #(
    parameter int AW = `WBUF_PAGES_LOG2 + `WBUF_DEPTH_LOG2  // read address width
) (
    input  wire logic                   rclk,
    input  wire logic                   we,        // host write strobe
    input  wire logic [AW:0]            waddr,     // {page, word, half}
    input  wire logic [`WBUF_HOST_W-1:0] data_in,   // host word
    input  wire logic                   ren,       // load read latch
    input  wire logic [AW-1:0]          raddr,     // {page, word}
    input  wire logic                   regen,     // load output reg
    output logic      [`WBUF_MEM_W-1:0]  data_out   // toward memory
);

    localparam int WORDS = 1 << AW;         // 64-bit words total
    localparam int HW    = `WBUF_HOST_W;    // half width

    logic [`WBUF_MEM_W-1:0] mem [WORDS];   // storage array
    logic [`WBUF_MEM_W-1:0] rd_latch;      // first read stage
    logic [AW-1:0]          wword;         // target 64-bit word of host write

    assign wword = waddr[AW:1];            // drop half select

    // host side, half-word writes
    always_ff @(posedge rclk) begin
        if (we) begin
            if (waddr[0]) begin
                mem[wword][`WBUF_MEM_W-1:HW] <= data_in;  // odd addr, upper half
            end else begin
                mem[wword][HW-1:0] <= data_in;            // even addr, lower half
            end
        end
    end

    // two-deep read pipe, latch then output reg
    always_ff @(posedge rclk) begin
        if (ren) begin
            rd_latch <= mem[raddr];        // stage 1
        end
        if (regen) begin
            data_out <= rd_latch;          // stage 2, independent enable
        end
    end

endmodule

`default_nettype wire

// ==== source/wbuf_pkg.sv ====
`default_nettype none
`include "wbuf_macros.svh"

package wbuf_pkg;

    typedef logic [$clog2(`WBUF_CHANNELS)-1:0] chan_t;     // channel index
    typedef logic [`WBUF_PAGES_LOG2-1:0]       page_t;     // page number
    typedef logic [`WBUF_DEPTH_LOG2-1:0]       mem_addr_t; // 64-bit word within page

    // local host address, one channel buffer
    typedef struct packed {
        page_t     page;  // top bits
        mem_addr_t word;  // memory word in page
        logic      half;  // 1 selects upper 32 bits
    } host_addr_t;

    typedef logic [`WBUF_HOST_W-1:0]   host_data_t;
    typedef logic [`WBUF_MEM_W-1:0]    mem_data_t;  // low half from even host addr
    typedef logic [`WBUF_DEPTH_LOG2:0] burst_len_t; // 1..128 valid

    // channel index to one-hot select
    function automatic logic [`WBUF_CHANNELS-1:0] chan_onehot(input chan_t c);
        logic [`WBUF_CHANNELS-1:0] oh;
        oh    = '0;
        oh[c] = 1'b1;
        return oh;
    endfunction

endpackage

`default_nettype wire

// ==== source/wbuf_macros.svh ====
`ifndef WBUF_MACROS_SVH
`define WBUF_MACROS_SVH

// number of channel buffers, any power of two
`define WBUF_CHANNELS 4

// page select width, 4 pages per channel
`define WBUF_PAGES_LOG2 2

// page depth in 64-bit memory words, 128 per page
`define WBUF_DEPTH_LOG2 7

// host side word
`define WBUF_HOST_W 32

// memory side word, two host words
`define WBUF_MEM_W 64

`endif
